/* project.f */
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/retire_trace.sv
verilog/pipe_core.sv
tests/pipe_core_asserts.sv
tests/pipe_core_tb.sv

/* tests/pipe_core_asserts.sv */
/*
 * pipe_core assertions
 * stream handshake rules, the hold freeze and the quiet window after reset
 */
`timescale 1ns/10ps

module pipe_core_asserts (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input pipe_pkg::instr_t in_instr,
    input logic             in_ready,
    input logic             trace_valid,
    input pipe_pkg::trace_t trace,
    input logic             trace_ready,
    input logic             hold,
    input pipe_pkg::mw_t    mw
);

    // offered instruction waits unchanged until taken
    in_offer_stable: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_instr))
        else $error("in_valid dropped or in_instr changed before acceptance");

    // record stays up and unchanged under back-pressure
    trace_offer_stable: assert property (@(posedge clk) disable iff (rst)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace))
        else $error("trace_valid dropped or trace changed before transfer");

    // a blocked record raises hold, shuts the input and freezes the last stage
    hold_freeze: assert property (@(posedge clk) disable iff (rst)
        trace_valid && !trace_ready |-> hold && !in_ready
            ##1 $stable(mw.valid) && $stable(mw.instr) && $stable(mw.result))
        else $error("blocked trace record did not freeze the pipeline");

    // four stages to fill before anything can retire
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !trace_valid [*4])
        else $error("trace record valid too early after reset");

endmodule

bind pipe_core pipe_core_asserts i_asserts (.*);

/* tests/pipe_core_tb.sv */
/*
 * pipe_core testbench
 * directed and random instruction streams checked against a register and
 * memory model, every trace record compared in order
 */
`timescale 1ns/10ps

module pipe_core_tb;

    localparam int SEND_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT = 400;

    // one expected record, queued when the instruction is taken
    typedef struct packed {
        pipe_pkg::seq_t       seq;
        pipe_pkg::instr_t     instr;
        pipe_pkg::word_t      result;
        logic                 chk_stall;
        pipe_pkg::stall_cnt_t stall;
    } exp_rec_t;

    logic             clk;
    logic             rst;
    logic             in_valid;
    pipe_pkg::instr_t in_instr;
    logic             in_ready;
    logic             trace_valid;
    pipe_pkg::trace_t trace;
    logic             trace_ready;
    // random trace stalls on or off
    logic             bp_on;

    pipe_pkg::word_t  ref_regs [pipe_pkg::N_REGS];
    pipe_pkg::word_t  ref_mem [pipe_pkg::MEM_WORDS];
    pipe_pkg::seq_t   ref_seq;
    exp_rec_t         exp_q [$];
    int               check_errors = 0;
    int               timeout_errors = 0;
    int               records = 0;

    pipe_core i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .trace_valid (trace_valid),
        .trace       (trace),
        .trace_ready (trace_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // trace consumer, driven just after the edge
    always @(posedge clk) begin : consumer
        logic random_on;
        // mode as it stood at the edge
        random_on = bp_on;
        #1;
        trace_ready = random_on ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic pipe_pkg::instr_t reg_form(input pipe_pkg::opcode_e op,
                                                 input int rd, input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    function automatic pipe_pkg::instr_t imm_form(input pipe_pkg::opcode_e op,
                                                 input int rd, input int rs, input int imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    // architectural result in program order
    task automatic model_issue(input pipe_pkg::instr_t ins, input logic chk, input int stall);
        pipe_pkg::reg_addr_t rd;
        pipe_pkg::reg_addr_t rs;
        pipe_pkg::reg_addr_t rt;
        pipe_pkg::word_t     imm;
        pipe_pkg::word_t     ea;
        pipe_pkg::word_t     res;
        exp_rec_t            e;
        rd  = ins[11:9];
        rs  = ins[8:6];
        rt  = ins[5:3];
        imm = {{10{ins[5]}}, ins[5:0]};
        ea  = ref_regs[rs] + imm;
        case (ins[15:12])
            pipe_pkg::OP_ADD:  res = ref_regs[rs] + ref_regs[rt];
            pipe_pkg::OP_SUB:  res = ref_regs[rs] - ref_regs[rt];
            pipe_pkg::OP_ADDI: res = ea;
            // 16 words, upper address bits dropped
            pipe_pkg::OP_LD:   res = ref_mem[ea[3:0]];
            pipe_pkg::OP_ST: begin
                res = ref_regs[rd];
                ref_mem[ea[3:0]] = ref_regs[rd];
            end
            default:           res = '0;
        endcase
        // r0 never written
        if (ins[15:12] inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_ADDI,
                               pipe_pkg::OP_LD} && rd != '0) begin
            ref_regs[rd] = res;
        end
        e.seq       = ref_seq;
        e.instr     = ins;
        e.result    = res;
        e.chk_stall = chk;
        e.stall     = pipe_pkg::stall_cnt_t'(stall);
        exp_q.push_back(e);
        ref_seq++;
    endtask

    // offer one instruction, hold it until in_ready
    task automatic send(input pipe_pkg::instr_t ins, input logic chk, input int stall);
        int   waited;
        logic taken;
        in_valid = 1'b1;
        in_instr = ins;
        waited   = 0;
        taken    = 1'b0;
        // in_ready is settled at the falling edge
        while (!taken && waited < SEND_TIMEOUT) begin
            @(negedge clk);
            taken = in_ready;
            waited++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        assert (taken) else begin
            $display("timeout: instruction %h was never accepted", ins);
            timeout_errors++;
        end
        if (taken) begin
            model_issue(ins, chk, stall);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // wait until every queued record came out
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d trace records never arrived", exp_q.size());
            timeout_errors++;
        end
    endtask

    //////////////////////////////
    // record checker
    //////////////////////////////
    task automatic check_record(input pipe_pkg::trace_t t);
        exp_rec_t         e;
        pipe_pkg::cycle_t lat;
        records++;
        assert (exp_q.size() != 0) else begin
            $display("record with seq %0d arrived with nothing outstanding", t.seq);
            check_errors++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_val("trace.seq", 16'(t.seq), 16'(e.seq));
            check_val("trace.instr", t.instr, e.instr);
            check_val("trace.result", t.result, e.result);
            if (e.chk_stall) begin
                check_val("trace.stall_cnt", 16'(t.stall_cnt), 16'(e.stall));
            end
            lat = t.retire_cycle - t.fetch_cycle;
            // four stages plus every held cycle, until the counter saturates
            if (t.stall_cnt != pipe_pkg::STALL_MAX) begin
                check_val("retire_cycle - fetch_cycle", lat, 16'(4 + t.stall_cnt));
            end else begin
                assert (lat >= 16'd19) else begin
                    $display("Fail at %0t: latency %0d short for a saturated stall_cnt",
                             $time, lat);
                    check_errors++;
                end
            end
        end
    endtask

    // handshake inputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && trace_valid && trace_ready) begin
            check_record(trace);
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////
    task automatic reset_state();
        check_val("trace_valid", 16'(trace_valid), 16'd0);
        check_val("in_ready", 16'(in_ready), 16'd1);
        // first record must carry seq 0
        send(16'h0000, 1'b1, 0);
        drain();
    endtask

    task automatic alu_stream();
        pipe_pkg::instr_t ins;
        for (int i = 0; i < 24; i++) begin
            ins = {4'($urandom_range(1, 3)), 12'($urandom)};
            send(ins, 1'b1, 0);
            idle($urandom_range(0, 2));
        end
        // r0 ignores the write
        send(imm_form(pipe_pkg::OP_ADDI, 0, 0, 7), 1'b1, 0);
        send(reg_form(pipe_pkg::OP_ADD, 6, 0, 0), 1'b1, 0);
        drain();
    endtask

    task automatic forward_chain();
        send(imm_form(pipe_pkg::OP_ADDI, 1, 0, 5), 1'b1, 0);
        // from xm
        send(imm_form(pipe_pkg::OP_ADDI, 2, 1, 3), 1'b1, 0);
        // r1 from write-back, r2 from xm
        send(reg_form(pipe_pkg::OP_ADD, 3, 1, 2), 1'b1, 0);
        send(reg_form(pipe_pkg::OP_SUB, 4, 3, 1), 1'b1, 0);
        send(reg_form(pipe_pkg::OP_ADD, 5, 4, 4), 1'b1, 0);
        drain();
    endtask

    task automatic load_store();
        send(imm_form(pipe_pkg::OP_ADDI, 1, 0, 9), 1'b1, 0);
        send(imm_form(pipe_pkg::OP_ADDI, 2, 0, 3), 1'b1, 0);
        // store then load the same word
        send(imm_form(pipe_pkg::OP_ST, 1, 2, 2), 1'b1, 0);
        send(imm_form(pipe_pkg::OP_LD, 3, 2, 2), 1'b1, 0);
        // load-use on rs
        send(reg_form(pipe_pkg::OP_ADD, 4, 3, 1), 1'b1, 1);
        // negative offset, store data forwarded from the alu
        send(imm_form(pipe_pkg::OP_ADDI, 6, 0, -3), 1'b1, 0);
        send(imm_form(pipe_pkg::OP_ST, 6, 2, -1), 1'b1, 0);
        send(imm_form(pipe_pkg::OP_LD, 7, 2, -1), 1'b1, 0);
        // load-use on rt
        send(reg_form(pipe_pkg::OP_SUB, 5, 6, 7), 1'b1, 1);
        // load-use through store data
        send(imm_form(pipe_pkg::OP_LD, 1, 2, 2), 1'b1, 0);
        send(imm_form(pipe_pkg::OP_ST, 1, 0, 0), 1'b1, 1);
        drain();
    endtask

    task automatic backpressure_stream();
        bp_on = 1'b1;
        // every opcode, unused codes run as nop
        for (int i = 0; i < 40; i++) begin
            send({4'($urandom_range(0, 7)), 12'($urandom)}, 1'b0, 0);
            idle($urandom_range(0, 1));
        end
        drain();
        bp_on = 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        void'($urandom(32'h5b6e9f8f));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_instr    = '0;
        trace_ready = 1'b1;
        bp_on       = 1'b0;
        ref_seq     = '0;
        for (int i = 0; i < pipe_pkg::N_REGS; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_state();
        alu_stream();
        forward_chain();
        load_store();
        backpressure_stream();
        $display("records %0d, failed checks %0d, timeouts %0d",
                 records, check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/decode_stage.sv */
/*
 * decode stage
 * register file with write-first read, field and immediate decode,
 * load-use detection with a one-cycle bubble
 */
`timescale 1ns/10ps

module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  pipe_pkg::fd_t   fd,
    input  logic            hold,
    input  pipe_pkg::wb_t   wb,
    output pipe_pkg::dx_t   dx,
    output logic            stall
);

    pipe_pkg::word_t     regs [pipe_pkg::N_REGS];
    pipe_pkg::opcode_e   op_raw;
    pipe_pkg::opcode_e   op;
    pipe_pkg::reg_addr_t rd;
    pipe_pkg::reg_addr_t rs;
    pipe_pkg::reg_addr_t rt;
    pipe_pkg::word_t     imm;
    logic                uses_rs;
    logic                uses_rt;
    logic                uses_rd;

    // r0 is hardwired, a same-cycle write wins over the array
    function automatic pipe_pkg::word_t read_reg(input pipe_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.we && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    //////////////////////////////
    // field decode
    //////////////////////////////
    always_comb begin
        op_raw = pipe_pkg::opcode_e'(fd.instr[15:12]);
        case (op_raw)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_ADDI,
            pipe_pkg::OP_LD, pipe_pkg::OP_ST: begin
                op = op_raw;
            end
            default: begin
                op = pipe_pkg::OP_NOP;
            end
        endcase
        rd  = fd.instr[11:9];
        rs  = fd.instr[8:6];
        // rt sits in the top half of the imm6 field
        rt  = fd.instr[5:3];
        imm = {{10{fd.instr[5]}}, fd.instr[5:0]};
        // which registers this instruction actually reads
        uses_rs = (op != pipe_pkg::OP_NOP);
        uses_rt = (op == pipe_pkg::OP_ADD) || (op == pipe_pkg::OP_SUB);
        uses_rd = (op == pipe_pkg::OP_ST);
    end

    // load still in execute and fd needs its value
    assign stall = dx.valid && (dx.op == pipe_pkg::OP_LD) && (dx.rd != '0) && fd.valid
                   && ((uses_rs && rs == dx.rd) || (uses_rt && rt == dx.rd)
                       || (uses_rd && rd == dx.rd));

    //////////////////////////////
    // register file
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_pkg::N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    //////////////////////////////
    // decode register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            dx.valid <= 1'b0;
        end else if (hold) begin
            if (dx.valid) begin
                dx.id <= pipe_pkg::bump_stall(dx.id);
            end
        end else if (stall) begin
            // bubble into execute, fd stays put
            dx.valid <= 1'b0;
        end else begin
            dx.valid   <= fd.valid;
            dx.instr   <= fd.instr;
            dx.op      <= op;
            dx.rd      <= rd;
            dx.rs      <= rs;
            dx.rt      <= rt;
            dx.a       <= read_reg(rs);
            // second operand is rt for add/sub, immediate otherwise
            dx.b       <= uses_rt ? read_reg(rt) : imm;
            dx.st_data <= read_reg(rd);
            dx.id      <= fd.id;
        end
    end

endmodule

/* verilog/execute_stage.sv */
/*
 * execute stage
 * alu and address generation with operand forwarding from memory
 * and write-back
 */
`timescale 1ns/10ps

module execute_stage (
    input  logic          clk,
    input  logic          rst,
    input  pipe_pkg::dx_t dx,
    input  logic          hold,
    input  pipe_pkg::wb_t wb,
    output pipe_pkg::xm_t xm
);

    pipe_pkg::word_t a_fwd;
    pipe_pkg::word_t b_fwd;
    pipe_pkg::word_t sd_fwd;
    pipe_pkg::word_t result;

    // younger producer in xm first, a load there has no data yet
    function automatic pipe_pkg::word_t fwd(input pipe_pkg::reg_addr_t src,
                                            input pipe_pkg::word_t     val);
        if (src == '0) begin
            return val;
        end
        if (xm.valid && xm.op != pipe_pkg::OP_LD && pipe_pkg::writes_reg(xm.op)
            && xm.rd == src) begin
            return xm.result;
        end
        if (wb.we && wb.rd == src) begin
            return wb.data;
        end
        return val;
    endfunction

    //////////////////////////////
    // operands and alu
    //////////////////////////////
    always_comb begin
        a_fwd = fwd(dx.rs, dx.a);
        // b is the immediate except for add/sub
        b_fwd = dx.b;
        if (dx.op == pipe_pkg::OP_ADD || dx.op == pipe_pkg::OP_SUB) begin
            b_fwd = fwd(dx.rt, dx.b);
        end
        // store data comes from rd
        sd_fwd = fwd(dx.rd, dx.st_data);
        case (dx.op)
            pipe_pkg::OP_ADD, pipe_pkg::OP_ADDI, pipe_pkg::OP_LD, pipe_pkg::OP_ST: begin
                result = a_fwd + b_fwd;
            end
            pipe_pkg::OP_SUB: begin
                result = a_fwd - b_fwd;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xm.valid <= 1'b0;
        end else if (hold) begin
            if (xm.valid) begin
                xm.id <= pipe_pkg::bump_stall(xm.id);
            end
        end else begin
            xm.valid   <= dx.valid;
            xm.instr   <= dx.instr;
            xm.op      <= dx.op;
            xm.rd      <= dx.rd;
            xm.result  <= result;
            xm.st_data <= sd_fwd;
            xm.id      <= dx.id;
        end
    end

endmodule

/* verilog/fetch_stage.sv */
/*
 * fetch stage
 * takes instructions off the input stream, tags them with a sequence number
 * and fetch cycle, and runs the free cycle counter
 */
`timescale 1ns/10ps

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pipe_pkg::instr_t in_instr,
    output logic             in_ready,
    input  logic             stall,
    input  logic             hold,
    output pipe_pkg::fd_t    fd,
    output pipe_pkg::cycle_t now
);

    // next sequence number to hand out
    pipe_pkg::seq_t seq;

    // accept only when decode will take the current word
    assign in_ready = !hold && !stall;

    //////////////////////////////
    // cycle counter
    //////////////////////////////
    // keeps running through stalls and back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            now <= '0;
        end else begin
            now <= now + 1'b1;
        end
    end

    //////////////////////////////
    // fetch register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            fd.valid <= 1'b0;
            seq      <= '0;
        end else if (in_ready) begin
            fd.valid <= in_valid;
            if (in_valid) begin
                fd.instr          <= in_instr;
                fd.id.seq         <= seq;
                // stamp with the counter value seen at the accepting edge
                fd.id.fetch_cycle <= now;
                fd.id.stall_cnt   <= '0;
                seq               <= seq + 1'b1;
            end
        end else if (fd.valid) begin
            // held by load-use or trace back-pressure
            fd.id <= pipe_pkg::bump_stall(fd.id);
        end
    end

endmodule

/* verilog/memory_stage.sv */
/*
 * memory stage
 * 16-word data memory, stores write at the edge, loads read into the result
 */
`timescale 1ns/10ps

module memory_stage (
    input  logic          clk,
    input  logic          rst,
    input  pipe_pkg::xm_t xm,
    input  logic          hold,
    output pipe_pkg::mw_t mw
);

    pipe_pkg::word_t     mem [pipe_pkg::MEM_WORDS];
    pipe_pkg::mem_addr_t addr;

    // low address bits only, upper bits ignored
    assign addr = xm.result[$bits(pipe_pkg::mem_addr_t)-1:0];

    //////////////////////////////
    // data memory
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (!hold && xm.valid && xm.op == pipe_pkg::OP_ST) begin
            mem[addr] <= xm.st_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mw.valid <= 1'b0;
        end else if (hold) begin
            if (mw.valid) begin
                mw.id <= pipe_pkg::bump_stall(mw.id);
            end
        end else begin
            mw.valid <= xm.valid;
            mw.instr <= xm.instr;
            mw.rd    <= xm.rd;
            // st is traced but never written back
            mw.we    <= pipe_pkg::writes_reg(xm.op);
            mw.id    <= xm.id;
            case (xm.op)
                pipe_pkg::OP_LD: mw.result <= mem[addr];
                // record shows the stored word
                pipe_pkg::OP_ST: mw.result <= xm.st_data;
                default:         mw.result <= xm.result;
            endcase
        end
    end

endmodule

/* verilog/pipe_core.sv */
/*
 * pipe_core
 * five-stage integer pipeline with retire tracer, instruction stream in,
 * trace record stream out
 */
`timescale 1ns/10ps

module pipe_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pipe_pkg::instr_t in_instr,
    output logic             in_ready,
    output logic             trace_valid,
    output pipe_pkg::trace_t trace,
    input  logic             trace_ready
);

    pipe_pkg::fd_t    fd;
    pipe_pkg::dx_t    dx;
    pipe_pkg::xm_t    xm;
    pipe_pkg::mw_t    mw;
    pipe_pkg::wb_t    wb;
    pipe_pkg::cycle_t now;
    // global freeze from trace back-pressure
    logic             hold;
    // load-use from decode
    logic             stall;

    fetch_stage i_fetch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .stall    (stall),
        .hold     (hold),
        .fd       (fd),
        .now      (now)
    );

    decode_stage i_decode (
        .clk   (clk),
        .rst   (rst),
        .fd    (fd),
        .hold  (hold),
        .wb    (wb),
        .dx    (dx),
        .stall (stall)
    );

    // wb doubles as the second forward source
    execute_stage i_execute (
        .clk  (clk),
        .rst  (rst),
        .dx   (dx),
        .hold (hold),
        .wb   (wb),
        .xm   (xm)
    );

    memory_stage i_memory (
        .clk  (clk),
        .rst  (rst),
        .xm   (xm),
        .hold (hold),
        .mw   (mw)
    );

    retire_trace i_retire (
        .clk         (clk),
        .rst         (rst),
        .mw          (mw),
        .now         (now),
        .trace_ready (trace_ready),
        .wb          (wb),
        .hold        (hold),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

endmodule

/* verilog/pipe_pkg.sv */
/*
 * pipe_pkg
 * shared types for the five-stage integer pipeline and its retire tracer
 */
package pipe_pkg;

    localparam int N_REGS    = 8;
    localparam int MEM_WORDS = 16;

    //////////////////////////////
    // basic widths
    //////////////////////////////
    typedef logic [15:0]                  word_t;
    typedef logic [15:0]                  instr_t;
    typedef logic [$clog2(N_REGS)-1:0]    reg_addr_t;
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_addr_t;
    typedef logic [7:0]                   seq_t;
    typedef logic [15:0]                  cycle_t;
    typedef logic [3:0]                   stall_cnt_t;

    // stall counter stops here
    localparam stall_cnt_t STALL_MAX = '1;

    // instr[15:12], unlisted codes run as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5
    } opcode_e;

    // per-instruction tracking, rides along every stage
    typedef struct packed {
        seq_t       seq;
        cycle_t     fetch_cycle;
        stall_cnt_t stall_cnt;
    } id_info_t;

    //////////////////////////////
    // stage registers
    //////////////////////////////
    typedef struct packed {
        logic     valid;
        instr_t   instr;
        id_info_t id;
    } fd_t;

    typedef struct packed {
        logic      valid;
        instr_t    instr;
        opcode_e   op;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     a;
        word_t     b;
        word_t     st_data;
        id_info_t  id;
    } dx_t;

    typedef struct packed {
        logic      valid;
        instr_t    instr;
        opcode_e   op;
        reg_addr_t rd;
        word_t     result;
        word_t     st_data;
        id_info_t  id;
    } xm_t;

    typedef struct packed {
        logic      valid;
        instr_t    instr;
        reg_addr_t rd;
        logic      we;
        word_t     result;
        id_info_t  id;
    } mw_t;

    // register write port, also the write-back forward source
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // one record per retired instruction
    typedef struct packed {
        seq_t       seq;
        instr_t     instr;
        word_t      result;
        cycle_t     fetch_cycle;
        cycle_t     retire_cycle;
        stall_cnt_t stall_cnt;
    } trace_t;

    // ops that end with a register write
    function automatic logic writes_reg(input opcode_e op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_ADDI) || (op == OP_LD);
    endfunction

    // one more held cycle, saturating
    function automatic id_info_t bump_stall(input id_info_t id);
        id_info_t r;
        r = id;
        if (r.stall_cnt != STALL_MAX) begin
            r.stall_cnt = r.stall_cnt + 1'b1;
        end
        return r;
    endfunction

endpackage

/* verilog/retire_trace.sv */
/*
 * retire tracer
 * write-back to the register file plus one packed trace record per
 * retired instruction, with back-pressure freezing the pipeline
 */
`timescale 1ns/10ps

module retire_trace (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::mw_t    mw,
    input  pipe_pkg::cycle_t now,
    input  logic             trace_ready,
    output pipe_pkg::wb_t    wb,
    output logic             hold,
    output logic             trace_valid,
    output pipe_pkg::trace_t trace
);

    // record waiting and not taken, nothing may move
    assign hold = trace_valid && !trace_ready;

    //////////////////////////////
    // write-back port
    //////////////////////////////
    // write lands on the same edge the record is captured
    always_comb begin
        wb.we   = mw.valid && mw.we && !hold;
        wb.rd   = mw.rd;
        wb.data = mw.result;
    end

    //////////////////////////////
    // trace record
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
        end else if (!hold) begin
            // free or just taken, load whatever retires now
            trace_valid <= mw.valid;
        end
    end

    // payload follows the valid bit, frozen while held
    always_ff @(posedge clk) begin
        if (!hold && mw.valid) begin
            trace.seq          <= mw.id.seq;
            trace.instr        <= mw.instr;
            trace.result       <= mw.result;
            trace.fetch_cycle  <= mw.id.fetch_cycle;
            // counter value at the retiring edge
            trace.retire_cycle <= now;
            trace.stall_cnt    <= mw.id.stall_cnt;
        end
    end

endmodule
